/* stump_ensemble.f */
+incdir+.
vote_mem_pkg.sv
vote_job_pkg.sv
sample_mem.sv
mem_arbiter.sv
stump_core.sv
vote_counter.sv
ensemble_ctrl.sv
stump_ensemble.sv
tb_stump_ensemble.sv

/* tb_stump_ensemble.sv */
`timescale 1ns/10ps
`default_nettype none
`include "stump_macros.svh"

module tb_stump_ensemble;

    import vote_mem_pkg::*;
    import vote_job_pkg::*;

    localparam int N_RANDOM    = 40;
    localparam int N_HOLD      = 6;
    localparam int JOB_COUNT   = 6 + N_RANDOM + N_HOLD;
    localparam int LOAD_CYCLES = 8 + 2 * (2 ** `MEM_AW + 2) + 4;
    localparam int LIMIT       = JOB_COUNT * `MAX_ROUNDS * 40 + LOAD_CYCLES;

    logic    clk;
    logic    rst;
    mem_wr_t wr;
    logic    wr_valid;
    logic    wr_ready;
    job_t    job;
    logic    job_valid;
    logic    job_ready;
    result_t result;
    logic    result_valid;
    logic    result_ready;

    // host view of the sample memory
    logic [`MEM_DW-1:0] mirror [2 ** `MEM_AW];
    logic [15:0]        lfsr;
    result_t            expected_q [$];
    result_t            exp_res;
    result_t            held_result;
    result_t            got;
    logic               busy;
    logic               held;
    int                 jobs_checked;

    stump_ensemble uut (
        .clk          (clk),
        .rst          (rst),
        .wr           (wr),
        .wr_valid     (wr_valid),
        .wr_ready     (wr_ready),
        .job          (job),
        .job_valid    (job_valid),
        .job_ready    (job_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    always #2 clk = ~clk;

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    // 16-bit galois lfsr stepped once per bit drawn
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // +1/-1 votes over all rounds on top of the even-count preset
    function automatic result_t expected_result(input job_t j);
        logic signed [`VOTE_W-1:0] sum;
        logic [15:0]               word;
        logic signed [9:0]         thr;
        logic signed [9:0]         feat;
        logic                      fires;
        int                        ones;
        result_t                   r;
        ones = 0;
        for (int c = 0; c < `NUM_CORES; c++) begin
            ones = ones + j.core_mask[c];
        end
        if ((j.rounds * ones) % 2 == 0) begin
            sum = j.tie_bit ? -1 : 1;
        end else begin
            sum = 0;
        end
        for (int rd = 0; rd < j.rounds; rd++) begin
            for (int c = 0; c < `NUM_CORES; c++) begin
                if (j.core_mask[c]) begin
                    word  = mirror[`STUMP_BASE + rd * `NUM_CORES + c];
                    thr   = word[9:0];
                    feat  = mirror[`FEAT_BASE + word[14:10]][9:0];
                    // polarity inverts the compare
                    fires = (feat >= thr) != word[15];
                    sum   = fires ? sum + 1 : sum - 1;
                end
            end
        end
        r.vote_sum  = sum;
        r.class_bit = sum < 0;
        return r;
    endfunction

    // one host write that must go through at once while idle
    task automatic write_word(input logic [`MEM_AW-1:0] addr, input logic [15:0] data);
        @(negedge clk);
        wr       = {addr, data};
        wr_valid = 1'b1;
        @(posedge clk);
        assert (wr_ready) else stop_fail("host write refused while the design was idle");
        mirror[addr] = data;
    endtask

    task automatic end_writes();
        @(negedge clk);
        wr_valid = 1'b0;
    endtask

    // submit a job and optionally stall the result for hold cycles
    task automatic run_job(input logic [3:0] rounds, input logic [3:0] mask,
                           input logic tie, input int hold, output result_t res);
        @(negedge clk);
        job          = '{rounds: rounds, core_mask: mask, tie_bit: tie};
        job_valid    = 1'b1;
        result_ready = (hold == 0);
        do @(posedge clk); while (!job_ready);
        @(negedge clk);
        job_valid = 1'b0;
        if (hold > 0) begin
            do @(posedge clk); while (!result_valid);
            repeat (hold) @(posedge clk);
            @(negedge clk);
            result_ready = 1'b1;
        end
        do @(posedge clk); while (!(result_valid && result_ready));
        res = result;
    endtask

    task automatic random_job(input int n, input int hold);
        logic [31:0] v;
        logic [3:0]  rounds;
        logic [3:0]  mask;
        logic [31:0] pick;
        logic [31:0] tie;
        v      = draw_bits(3);
        rounds = v[3:0] + 4'd1;
        v      = draw_bits(4);
        mask   = v[3:0];
        pick   = draw_bits(2);
        // single core every fourth job, and never an empty mask
        if (mask == 4'd0 || n % 4 == 0) begin
            mask = 4'd1 << pick[1:0];
        end
        tie = draw_bits(1);
        run_job(rounds, mask, tie[0], hold, got);
    endtask

    // checker sampled on the rising edge where handshakes happen
    always @(posedge clk) begin
        if (!rst) begin
            if (busy) begin
                assert (!job_ready) else stop_fail("job_ready rose before the result was taken");
            end
            if (held) begin
                assert (result_valid) else stop_fail("result_valid dropped under back-pressure");
                assert (result == held_result) else stop_fail($sformatf(
                    "CHECK FAILED: result got %h held %h", result, held_result));
            end
            if (job_valid && job_ready) begin
                expected_q.push_back(expected_result(job));
                busy = 1'b1;
            end
            if (result_valid && result_ready) begin
                assert (expected_q.size() > 0) else stop_fail("result seen with no job pending");
                exp_res = expected_q.pop_front();
                assert (result.vote_sum == exp_res.vote_sum) else stop_fail($sformatf(
                    "CHECK FAILED: result.vote_sum got %h expected %h",
                    result.vote_sum, exp_res.vote_sum));
                assert (result.class_bit == exp_res.class_bit) else stop_fail($sformatf(
                    "CHECK FAILED: result.class_bit got %h expected %h",
                    result.class_bit, exp_res.class_bit));
                // preset rules out a zero sum
                assert (result.vote_sum != 0) else stop_fail($sformatf(
                    "CHECK FAILED: result.vote_sum got %h expected nonzero", result.vote_sum));
                busy         = 1'b0;
                jobs_checked = jobs_checked + 1;
            end
            held        = result_valid && !result_ready;
            held_result = result;
        end
    end

    // watchdog
    initial begin
        repeat (LIMIT) @(posedge clk);
        stop_fail($sformatf("timeout: run did not finish within %0d cycles", LIMIT));
    end

    initial begin
        logic [31:0] v;
        clk          = 1'b0;
        rst          = 1'b1;
        wr           = '0;
        wr_valid     = 1'b0;
        job          = '0;
        job_valid    = 1'b0;
        result_ready = 1'b1;
        lfsr         = 16'd31;
        busy         = 1'b0;
        held         = 1'b0;
        jobs_checked = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle state after reset
        @(negedge clk);
        assert (!result_valid) else stop_fail("result_valid high after reset");
        assert (job_ready) else stop_fail("job_ready low after reset");

        // full random load
        for (int a = 0; a < 2 ** `MEM_AW; a++) begin
            v = draw_bits(16);
            write_word(a, v[15:0]);
        end
        end_writes();

        // one round, all cores, even total
        run_job(4'd1, 4'hF, 1'b0, 0, got);
        assert (got.vote_sum[0]) else stop_fail($sformatf(
            "CHECK FAILED: result.vote_sum got %h expected odd", got.vote_sum));
        run_job(4'd1, 4'hF, 1'b1, 0, got);

        // odd totals start at zero
        run_job(4'd3, 4'b0111, 1'b0, 0, got);
        run_job(4'd5, 4'b1011, 1'b1, 0, got);

        for (int n = 0; n < N_RANDOM; n++) begin
            random_job(n, 0);
        end

        // core 0 always +1, core 1 always -1
        write_word(`STUMP_BASE, 16'h0200);
        write_word(`STUMP_BASE + 1, 16'h8200);
        end_writes();
        run_job(4'd1, 4'b0011, 1'b0, 0, got);
        assert (got.vote_sum == 1 && !got.class_bit) else stop_fail($sformatf(
            "CHECK FAILED: result got %h expected %h", got, 9'h001));
        run_job(4'd1, 4'b0011, 1'b1, 0, got);
        assert (got.vote_sum == -1 && got.class_bit) else stop_fail($sformatf(
            "CHECK FAILED: result got %h expected %h", got, 9'h1FF));

        // result stalled for 1 to 16 cycles
        for (int n = 0; n < N_HOLD; n++) begin
            v = draw_bits(4);
            random_job(n + 1, v + 1);
        end

        @(negedge clk);
        if (jobs_checked == JOB_COUNT && expected_q.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_fail($sformatf("only %0d of %0d results were checked", jobs_checked, JOB_COUNT));
        end
    end

endmodule

`default_nettype wire

/* stump_ensemble.sv */
`timescale 1ns/10ps
`default_nettype none
`include "stump_macros.svh"

module stump_ensemble (
    input  wire                        clk,
    input  wire                        rst,
    input  wire vote_mem_pkg::mem_wr_t wr,
    input  wire                        wr_valid,
    output logic                       wr_ready,
    input  wire vote_job_pkg::job_t    job,
    input  wire                        job_valid,
    output logic                       job_ready,
    output vote_job_pkg::result_t      result,
    output logic                       result_valid,
    input  wire                        result_ready
);

    import vote_job_pkg::*;

    // core side of the arbiter
    core_req_t [`NUM_CORES-1:0] core_req;
    core_rsp_t                  core_rsp;
    logic [`NUM_CORES-1:0]      core_req_valid;
    logic [`NUM_CORES-1:0]      core_req_ready;
    logic [`NUM_CORES-1:0]      core_rsp_valid;

    // round control and votes
    logic [`NUM_CORES-1:0]      start_mask;
    logic [`ROUND_W-1:0]        round_idx;
    logic [`NUM_CORES-1:0]      core_done;
    logic [`NUM_CORES-1:0]      core_vote;
    logic [`NUM_CORES-1:0]      core_enable;
    logic                       preset;
    logic                       total_even;
    logic                       tie_bit;
    logic                       update;
    logic signed [`VOTE_W-1:0]  vote_sum;
    logic                       sign_bit;

    mem_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .req_valid (core_req_valid),
        .req       (core_req),
        .req_ready (core_req_ready),
        .rsp_valid (core_rsp_valid),
        .rsp       (core_rsp),
        .wr        (wr),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready)
    );

    // peer cores with one stump slot each
    for (genvar k = 0; k < `NUM_CORES; k++) begin : g_core
        stump_core #(
            .CORE_ID (k)
        ) u_core (
            .clk         (clk),
            .rst         (rst),
            .round_start (start_mask[k]),
            .round_idx   (round_idx),
            .req_valid   (core_req_valid[k]),
            .req         (core_req[k]),
            .req_ready   (core_req_ready[k]),
            .rsp_valid   (core_rsp_valid[k]),
            .rsp         (core_rsp),
            .done        (core_done[k]),
            .vote        (core_vote[k])
        );
    end

    vote_counter u_cnt (
        .clk         (clk),
        .rst         (rst),
        .preset      (preset),
        .total_even  (total_even),
        .tie_bit     (tie_bit),
        .update      (update),
        .core_enable (core_enable),
        .core_vote   (core_vote),
        .vote_sum    (vote_sum),
        .sign_bit    (sign_bit)
    );

    // sign of the sum gives the class
    ensemble_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .job          (job),
        .job_valid    (job_valid),
        .job_ready    (job_ready),
        .round_start  (start_mask),
        .round_idx    (round_idx),
        .core_done    (core_done),
        .preset       (preset),
        .total_even   (total_even),
        .tie_bit      (tie_bit),
        .update       (update),
        .core_enable  (core_enable),
        .vote_sum     (vote_sum),
        .sign_bit     (sign_bit),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

endmodule

`default_nettype wire

/* ensemble_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "stump_macros.svh"

module ensemble_ctrl (
    input  wire                       clk,
    input  wire                       rst,
    input  wire vote_job_pkg::job_t   job,
    input  wire                       job_valid,
    output logic                      job_ready,
    output logic [`NUM_CORES-1:0]     round_start,
    output logic [`ROUND_W-1:0]       round_idx,
    input  wire [`NUM_CORES-1:0]      core_done,
    output logic                      preset,
    output logic                      total_even,
    output logic                      tie_bit,
    output logic                      update,
    output logic [`NUM_CORES-1:0]     core_enable,
    input  wire signed [`VOTE_W-1:0]  vote_sum,
    input  wire                       sign_bit,
    output vote_job_pkg::result_t     result,
    output logic                      result_valid,
    input  wire                       result_ready
);

    import vote_job_pkg::*;

    typedef enum logic [2:0] {
        C_IDLE,
        C_PRESET,
        C_START,
        C_WAIT,
        C_UPDATE,
        C_RESULT
    } state_t;

    state_t state;
    job_t   job_q;
    logic   all_done;
    logic   last_round;

    // disabled cores count as finished
    assign all_done   = &(core_done | ~job_q.core_mask);
    assign last_round = (round_idx + 1'b1) == job_q.rounds;

    // product is odd only when both rounds and popcount are odd
    assign total_even  = !(job_q.rounds[0] && (^job_q.core_mask));
    assign tie_bit     = job_q.tie_bit;
    assign core_enable = job_q.core_mask;

    // pulses and handshakes straight from the state
    assign job_ready    = state == C_IDLE;
    assign preset       = state == C_PRESET;
    assign round_start  = (state == C_START) ? job_q.core_mask : '0;
    assign update       = state == C_UPDATE;
    assign result_valid = state == C_RESULT;

    // counter holds still while the result waits
    assign result = '{class_bit: sign_bit, vote_sum: vote_sum};

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= C_IDLE;
            round_idx <= '0;
        end else begin
            case (state)
                C_IDLE: begin
                    if (job_valid) begin
                        round_idx <= '0;
                        state     <= C_PRESET;
                    end
                end
                C_PRESET: state <= C_START;
                C_START:  state <= C_WAIT;
                C_WAIT: begin
                    if (all_done) begin
                        state <= C_UPDATE;
                    end
                end
                C_UPDATE: begin
                    if (last_round) begin
                        state <= C_RESULT;
                    end else begin
                        round_idx <= round_idx + 1'b1;
                        state     <= C_START;
                    end
                end
                C_RESULT: begin
                    if (result_ready) begin
                        state <= C_IDLE;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    // job copy taken on acceptance
    always_ff @(posedge clk) begin
        if (state == C_IDLE && job_valid) begin
            job_q <= job;
        end
    end

endmodule

`default_nettype wire

/* vote_counter.sv */
`timescale 1ns/10ps
`default_nettype none
`include "stump_macros.svh"

module vote_counter (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        preset,
    input  wire                        total_even,
    input  wire                        tie_bit,
    input  wire                        update,
    input  wire [`NUM_CORES-1:0]       core_enable,
    input  wire [`NUM_CORES-1:0]       core_vote,
    output logic signed [`VOTE_W-1:0]  vote_sum,
    output logic                       sign_bit
);

    logic signed [1:0]         sel [`NUM_CORES];
    logic signed [`VOTE_W-1:0] step;
    logic signed [`VOTE_W-1:0] preset_val;

    // per core weight of 0 when off and +1 or -1 otherwise
    always_comb begin
        for (int k = 0; k < `NUM_CORES; k++) begin
            if (!core_enable[k]) begin
                sel[k] = 2'sb00;
            end else if (core_vote[k]) begin
                sel[k] = 2'sb01;
            end else begin
                sel[k] = 2'sb11;
            end
        end
    end

    // four weights summed with sign extension
    always_comb begin
        step = '0;
        for (int k = 0; k < `NUM_CORES; k++) begin
            step = step + {{(`VOTE_W - 2){sel[k][1]}}, sel[k]};
        end
    end

    // even vote count starts one off zero so the sum cannot tie
    // tie_bit 0 leans positive and 1 leans negative
    always_comb begin
        if (!total_even) begin
            preset_val = '0;
        end else if (tie_bit) begin
            preset_val = '1;
        end else begin
            preset_val = {{(`VOTE_W - 1){1'b0}}, 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vote_sum <= '0;
        end else if (preset) begin
            vote_sum <= preset_val;
        end else if (update) begin
            vote_sum <= vote_sum + step;
        end
    end

    // negative sum means class 1
    assign sign_bit = vote_sum[`VOTE_W-1];

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(preset && update));

endmodule

`default_nettype wire

/* stump_core.sv */
`timescale 1ns/10ps
`default_nettype none
`include "stump_macros.svh"

module stump_core #(
    parameter int CORE_ID = 0
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          round_start,
    input  wire [`ROUND_W-1:0]           round_idx,
    output logic                         req_valid,
    output vote_job_pkg::core_req_t      req,
    input  wire                          req_ready,
    input  wire                          rsp_valid,
    input  wire vote_job_pkg::core_rsp_t rsp,
    output logic                         done,
    output logic                         vote
);

    import vote_mem_pkg::*;

    localparam int AW = `MEM_AW;

    typedef enum logic [1:0] {
        S_IDLE,
        S_STUMP,
        S_FEAT
    } state_t;

    state_t        state;
    stump_t        stump_q;
    feature_t      feat;
    logic [AW-1:0] stump_addr;
    logic [AW-1:0] feat_addr;
    logic          ge;

    // stump slot for this round and this core
    assign stump_addr = AW'(`STUMP_BASE) + AW'(round_idx) * AW'(`NUM_CORES) + AW'(CORE_ID);

    // feature named by the returning stump word
    assign feat_addr = AW'(`FEAT_BASE) + AW'(rsp.data.stump.feat_idx);

    // both sides are 10-bit signed
    assign feat = rsp.data.feature;
    assign ge   = $signed(feat.value) >= $signed(stump_q.threshold);

    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            req_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            // drop the request once the arbiter takes it
            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    if (round_start) begin
                        done      <= 1'b0;
                        req_valid <= 1'b1;
                        state     <= S_STUMP;
                    end
                end
                S_STUMP: begin
                    // stump in hand, go for the feature
                    if (rsp_valid) begin
                        req_valid <= 1'b1;
                        state     <= S_FEAT;
                    end
                end
                S_FEAT: begin
                    if (rsp_valid) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // address, stump and vote
    always_ff @(posedge clk) begin
        if (state == S_IDLE && round_start) begin
            req.addr <= stump_addr;
        end
        if (state == S_STUMP && rsp_valid) begin
            stump_q  <= rsp.data.stump;
            req.addr <= feat_addr;
        end
        // polarity flips the comparison
        if (state == S_FEAT && rsp_valid) begin
            vote <= ge ^ stump_q.polarity;
        end
    end

    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        (state == S_IDLE) |-> !req_valid);

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none
`include "stump_macros.svh"

module mem_arbiter (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire [`NUM_CORES-1:0]                     req_valid,
    input  wire vote_job_pkg::core_req_t [`NUM_CORES-1:0] req,
    output logic [`NUM_CORES-1:0]                    req_ready,
    output logic [`NUM_CORES-1:0]                    rsp_valid,
    output vote_job_pkg::core_rsp_t                  rsp,
    input  wire vote_mem_pkg::mem_wr_t               wr,
    input  wire                                      wr_valid,
    output logic                                     wr_ready
);

    import vote_job_pkg::*;
    import vote_mem_pkg::*;

    localparam int IDW = $clog2(`NUM_CORES);

    logic [IDW-1:0]        last_id;
    logic [IDW-1:0]        grant_id;
    logic [`NUM_CORES-1:0] grant;
    logic [`NUM_CORES-1:0] rsp_sel;
    logic                  any_req;
    core_req_t             granted_req;
    logic [`MEM_AW-1:0]    mem_addr;
    logic                  mem_we;
    mem_word_u             mem_rdata;

    assign any_req = |req_valid;

    // round robin, search starts just past the last winner
    always_comb begin
        logic [IDW-1:0] idx;
        grant    = '0;
        grant_id = last_id;
        for (int i = 1; i <= `NUM_CORES; i++) begin
            idx = last_id + IDW'(i);
            if (grant == '0 && req_valid[idx]) begin
                grant[idx] = 1'b1;
                grant_id   = idx;
            end
        end
    end

    // cores first, host only on a quiet cycle
    assign req_ready   = grant;
    assign wr_ready    = !any_req;
    assign granted_req = req[grant_id];
    assign mem_addr    = any_req ? granted_req.addr : wr.addr;
    assign mem_we      = !any_req && wr_valid;

    // pointer and response owner
    always_ff @(posedge clk) begin
        if (rst) begin
            last_id <= IDW'(`NUM_CORES - 1);
            rsp_sel <= '0;
        end else begin
            rsp_sel <= grant;
            if (any_req) begin
                last_id <= grant_id;
            end
        end
    end

    // data goes to everyone, valid only to last cycle's winner
    assign rsp_valid = rsp_sel;
    assign rsp.data  = mem_rdata;

    sample_mem u_mem (
        .clk   (clk),
        .addr  (mem_addr),
        .we    (mem_we),
        .wdata (wr.data),
        .rdata (mem_rdata)
    );

    // single owner of the memory port per cycle
    a_one_owner: assert property (@(posedge clk) disable iff (rst)
        $onehot0(req_ready) && !(|req_ready && wr_ready));

endmodule

`default_nettype wire

/* sample_mem.sv */
`timescale 1ns/10ps
`default_nettype none
`include "stump_macros.svh"

module sample_mem (
    input  wire                          clk,
    input  wire [`MEM_AW-1:0]            addr,
    input  wire                          we,
    input  wire vote_mem_pkg::mem_word_u wdata,
    output vote_mem_pkg::mem_word_u      rdata
);

    import vote_mem_pkg::*;

    localparam int DEPTH = 2 ** `MEM_AW;

    // feature region then stump region
    mem_word_u mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, one cycle after addr
    // a write to the same address returns the old word
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* vote_job_pkg.sv */
`default_nettype none
`include "stump_macros.svh"

package vote_job_pkg;

    import vote_mem_pkg::*;

    // job descriptor from host
    // rounds runs 1 to MAX_ROUNDS
    typedef struct packed {
        logic [`ROUND_W-1:0]   rounds;
        logic [`NUM_CORES-1:0] core_mask;
        logic                  tie_bit;
    } job_t;

    // result back to host
    // class_bit high means a negative sum
    typedef struct packed {
        logic                      class_bit;
        logic signed [`VOTE_W-1:0] vote_sum;
    } result_t;

    // core read request, address only
    typedef struct packed {
        logic [`MEM_AW-1:0] addr;
    } core_req_t;

    // read data returned to the cores
    // shared by all cores, rsp_valid picks the owner
    typedef struct packed {
        mem_word_u data;
    } core_rsp_t;

endpackage

`default_nettype wire

/* vote_mem_pkg.sv */
`default_nettype none
`include "stump_macros.svh"

package vote_mem_pkg;

    // feature word, only the low 10 bits carry data
    typedef struct packed {
        logic [5:0]        pad;
        logic signed [9:0] value;
    } feature_t;

    // stump descriptor
    // polarity set means the vote is inverted
    typedef struct packed {
        logic              polarity;
        logic [4:0]        feat_idx;
        logic signed [9:0] threshold;
    } stump_t;

    // one memory word, read either as feature or as stump
    typedef union packed {
        feature_t feature;
        stump_t   stump;
    } mem_word_u;

    // host write beat
    typedef struct packed {
        logic [`MEM_AW-1:0] addr;
        mem_word_u          data;
    } mem_wr_t;

endpackage

`default_nettype wire

/* stump_macros.svh */
`ifndef STUMP_MACROS_SVH
`define STUMP_MACROS_SVH

// number of stump cores, arbiter and vote adder are built for four
`define NUM_CORES 4

// sample memory, 64 words of 16 bits
`define MEM_AW 6
`define MEM_DW 16

// region bases, features low and stumps high
`define FEAT_BASE 0
`define STUMP_BASE 32

// job limits
`define MAX_ROUNDS 8
`define ROUND_W 4

// signed vote sum width
`define VOTE_W 8

`endif
